/* files.f */
verilog/rv_core_pkg.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_core.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := rv_core_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

$(BIN): $(FILELIST) $(wildcard verilog/*.sv sim/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

	localparam rv_core_pkg::word_t RESET_PC = 32'h0000_0000;
	localparam int CLK_PERIOD = 20;
	localparam int TOTAL_INSTS = 41;
	localparam int COMMIT_LIMIT = 20;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic fetch_valid = 1'b0;
	rv_core_pkg::inst_t fetch_inst = rv_core_pkg::NOP_INST;
	logic fetch_req;
	rv_core_pkg::word_t fetch_addr;
	logic commit_valid;
	logic commit_wen;
	rv_core_pkg::reg_addr_t commit_rd;
	rv_core_pkg::word_t commit_pc, commit_data, commit_next_pc;

	rv_core_pkg::inst_t imem [256];
	rv_core_pkg::word_t xreg [32];
	rv_core_pkg::word_t model_pc;
	rv_core_pkg::word_t mem_addr;
	logic mem_pending = 1'b0;
	int mem_wait;
	int draw;
	integer seed = 32'ha1152c32;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;

	always #(CLK_PERIOD / 2) clock = ~clock;

	rv_core #(.RESET_PC(RESET_PC)) i_dut (
		.clock(clock), .reset(reset),
		.fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
		.fetch_valid_i(fetch_valid), .fetch_inst_i(fetch_inst),
		.commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
		.commit_wen_o(commit_wen), .commit_rd_o(commit_rd),
		.commit_data_o(commit_data), .commit_next_pc_o(commit_next_pc)
	);

	// instruction memory answering 1 to 4 cycles after each request
	always @(posedge clock) begin
		fetch_valid <= 1'b0;
		if (reset) begin
			mem_pending <= 1'b0;
		end else if (mem_pending) begin
			if (mem_wait == 1) begin
				fetch_valid <= 1'b1;
				fetch_inst <= imem[mem_addr[9:2]];
				mem_pending <= 1'b0;
			end else begin
				mem_wait <= mem_wait - 1;
			end
		end else if (fetch_req) begin
			draw = 1 + ($unsigned($random(seed)) % 4);
			mem_addr <= fetch_addr;
			if (draw == 1) begin
				fetch_valid <= 1'b1;
				fetch_inst <= imem[fetch_addr[9:2]];
			end else begin
				mem_wait <= draw - 1;
				mem_pending <= 1'b1;
			end
		end
	end

	function automatic rv_core_pkg::inst_t op_imm(input int f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic rv_core_pkg::inst_t op_reg(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rv_core_pkg::inst_t lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic rv_core_pkg::inst_t jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic rv_core_pkg::inst_t branch(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	// architectural step of the instruction at model_pc
	task automatic model_step(output logic wen, output rv_core_pkg::reg_addr_t rd,
		output rv_core_pkg::word_t data, output rv_core_pkg::word_t next_pc);
		rv_core_pkg::inst_t inst;
		rv_core_pkg::word_t a, b;
		inst = imem[model_pc[9:2]];
		rd = inst[11:7];
		a = xreg[inst[19:15]];
		b = xreg[inst[24:20]];
		data = '0;
		wen = 1'b0;
		next_pc = model_pc + 4;
		if (inst[6:0] == 7'b0010011) begin
			b = {{20{inst[31]}}, inst[31:20]};
		end
		case (inst[6:0])
			7'b0010011, 7'b0110011: begin
				wen = 1'b1;
				case (inst[14:12])
					3'b000: data = (inst[5] && inst[30]) ? a - b : a + b;
					3'b001: data = a << b[4:0];
					3'b010: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: data = a ^ b;
					3'b101: begin
						if (inst[30]) begin
							data = $signed(a) >>> b[4:0];
						end else begin
							data = a >> b[4:0];
						end
					end
					3'b110: data = a | b;
					3'b111: data = a & b;
					default: wen = 1'b0;
				endcase
			end
			7'b0110111: begin
				data = {inst[31:12], 12'h000};
				wen = 1'b1;
			end
			7'b1101111: begin
				data = model_pc + 4;
				wen = 1'b1;
				next_pc = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
					inst[30:21], 1'b0};
			end
			7'b1100011: begin
				if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
					next_pc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
						inst[11:8], 1'b0};
				end
			end
			default: ;
		endcase
		wen = wen && (rd != 5'd0);
		if (wen) begin
			xreg[rd] = data;
		end
	endtask

	task automatic check_value(input string what, input rv_core_pkg::word_t got,
		input rv_core_pkg::word_t exp);
		check_count++;
		assert (got === exp) else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	// reset the core, clear the model registers and fill memory with unknown opcodes
	task automatic start_test();
		@(posedge clock);
		reset <= 1'b1;
		for (int i = 0; i < 32; i++) begin
			xreg[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			imem[i] = {i[24:0], 7'b0001011};
		end
	endtask

	task automatic run_program(input string name, input int n_inst);
		int start_errors;
		int seen;
		int idle;
		logic exp_wen;
		rv_core_pkg::reg_addr_t exp_rd;
		rv_core_pkg::word_t exp_data, exp_next;
		start_errors = error_count;
		seen = 0;
		idle = 0;
		model_pc = RESET_PC;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		while (seen < n_inst && idle < COMMIT_LIMIT) begin
			@(negedge clock);
			idle++;
			if (fetch_req) begin
				check_value("fetch_addr_o", fetch_addr, model_pc);
			end
			if (commit_valid) begin
				model_step(exp_wen, exp_rd, exp_data, exp_next);
				check_value("commit_pc_o", commit_pc, model_pc);
				check_value("commit_wen_o", {31'b0, commit_wen}, {31'b0, exp_wen});
				if (exp_wen) begin
					check_value("commit_rd_o", {27'b0, commit_rd}, {27'b0, exp_rd});
					check_value("commit_data_o", commit_data, exp_data);
				end
				check_value("commit_next_pc_o", commit_next_pc, exp_next);
				model_pc = exp_next;
				seen++;
				idle = 0;
			end
		end
		if (seen < n_inst) begin
			$display("%s: core stopped committing after %0d of %0d instructions",
				name, seen, n_inst);
			error_count++;
		end
		test_count++;
		$display("test %s done: %0d commits, %0d errors", name, seen, error_count - start_errors);
	endtask

	task automatic imm_alu_program();
		start_test();
		imem[0] = op_imm(0, 1, 0, 100);
		imem[1] = op_imm(0, 2, 0, -7);
		imem[2] = op_imm(2, 3, 2, -3);
		imem[3] = op_imm(2, 4, 1, -1);
		imem[4] = op_imm(4, 5, 1, 'h0f0);
		imem[5] = op_imm(6, 6, 2, 'h300);
		imem[6] = op_imm(7, 7, 2, 'h7f0);
		imem[7] = op_imm(1, 8, 2, 4);
		imem[8] = op_imm(5, 9, 2, 28);
		// srai by 2
		imem[9] = op_imm(5, 10, 2, 'h402);
		run_program("imm_alu", 10);
	endtask

	task automatic reg_alu_program();
		start_test();
		imem[0] = op_imm(0, 1, 0, 1234);
		imem[1] = op_imm(0, 2, 0, -99);
		imem[2] = op_imm(0, 3, 0, 5);
		imem[3] = op_reg(0, 0, 4, 1, 2);
		imem[4] = op_reg('h20, 0, 5, 1, 2);
		imem[5] = op_reg(0, 1, 6, 1, 3);
		imem[6] = op_reg(0, 2, 7, 2, 1);
		imem[7] = op_reg(0, 4, 8, 1, 2);
		imem[8] = op_reg(0, 5, 9, 2, 3);
		imem[9] = op_reg('h20, 5, 10, 2, 3);
		imem[10] = op_reg(0, 6, 11, 1, 2);
		imem[11] = op_reg(0, 7, 12, 1, 2);
		run_program("reg_alu", 12);
	endtask

	task automatic lui_x0_program();
		start_test();
		imem[0] = lui(1, 'habcde);
		imem[1] = lui(0, 'h12345);
		imem[2] = op_imm(0, 0, 1, 55);
		imem[3] = op_reg(0, 0, 2, 0, 1);
		imem[4] = op_reg(0, 6, 3, 0, 0);
		run_program("lui_x0", 5);
	endtask

	task automatic jump_branch_program();
		start_test();
		imem[0] = op_imm(0, 1, 0, 3);
		imem[1] = op_imm(0, 2, 0, 3);
		imem[2] = branch(0, 1, 2, 12);
		imem[3] = jal(0, 4);
		imem[4] = op_imm(0, 8, 7, 0);
		imem[5] = branch(1, 1, 2, 8);
		imem[6] = jal(5, 16);
		imem[10] = branch(0, 1, 0, 8);
		imem[11] = branch(1, 1, 0, 8);
		// backward jump into the middle
		imem[13] = jal(7, -40);
		run_program("jump_branch", 10);
	endtask

	task automatic unknown_opcode_program();
		start_test();
		imem[0] = op_imm(0, 1, 0, 9);
		imem[1] = 32'hffff_f0ff;
		imem[2] = 32'h0012_3087;
		imem[3] = op_imm(0, 2, 1, 1);
		run_program("unknown_opcode", 4);
	endtask

	initial begin
		#((TOTAL_INSTS * 10 + 200) * CLK_PERIOD);
		$display("timeout: the tests did not finish in the expected time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		imm_alu_program();
		reg_alu_program();
		lui_x0_program();
		jump_branch_program();
		unknown_opcode_program();
		$display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/rv_core_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
	input logic clock,
	input logic reset,
	input logic fetch_req_i,
	input logic fetch_valid_i,
	input logic commit_valid_i,
	input logic commit_wen_i,
	input rv_core_pkg::reg_addr_t commit_rd_i
);

	logic outstanding;

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= 1'b0;
		end else if (fetch_req_i) begin
			outstanding <= 1'b1;
		end else if (fetch_valid_i) begin
			outstanding <= 1'b0;
		end
	end

	single_request: assert property (@(posedge clock) disable iff (reset)
		fetch_req_i |-> !outstanding)
		else $error("fetch request issued while a response is outstanding");

	// three stages from memory response to retire
	commit_latency: assert property (@(posedge clock) disable iff (reset)
		commit_valid_i == $past(fetch_valid_i, 3))
		else $error("commit does not follow the fetch response by 3 cycles");

	refetch_latency: assert property (@(posedge clock) disable iff (reset)
		$past(commit_valid_i) |-> fetch_req_i)
		else $error("no fetch request in the cycle after a commit");

	no_x0_write: assert property (@(posedge clock) disable iff (reset)
		commit_wen_i |-> commit_rd_i != 5'd0)
		else $error("commit writes register x0");

endmodule

bind rv_core rv_core_assertions i_assertions (
	.clock(clock), .reset(reset),
	.fetch_req_i(fetch_req_o), .fetch_valid_i(fetch_valid_i),
	.commit_valid_i(commit_valid_o), .commit_wen_i(commit_wen_o),
	.commit_rd_i(commit_rd_o)
);

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	output logic fetch_req_o,
	output rv_core_pkg::word_t fetch_addr_o,
	input logic fetch_valid_i,
	input rv_core_pkg::inst_t fetch_inst_i,
	output logic commit_valid_o,
	output rv_core_pkg::word_t commit_pc_o,
	output logic commit_wen_o,
	output rv_core_pkg::reg_addr_t commit_rd_o,
	output rv_core_pkg::word_t commit_data_o,
	output rv_core_pkg::word_t commit_next_pc_o
);

	logic if_valid;
	rv_core_pkg::word_t if_pc;
	rv_core_pkg::inst_t if_inst;

	rv_core_pkg::reg_addr_t rs1_addr, rs2_addr;
	rv_core_pkg::word_t rs1_data, rs2_data;

	logic id_valid;
	rv_core_pkg::word_t id_pc, id_op_a, id_op_b, id_rs2_val, id_imm;
	rv_core_pkg::alu_op_e id_alu_op;
	rv_core_pkg::next_pc_sel_e id_next_pc_sel;
	rv_core_pkg::reg_addr_t id_rd;
	logic id_rd_wen;

	// retire feeds back into fetch
	rv_fetch #(.RESET_PC(RESET_PC)) i_fetch (
		.clock(clock), .reset(reset),
		.fetch_req_o(fetch_req_o), .fetch_addr_o(fetch_addr_o),
		.fetch_valid_i(fetch_valid_i), .fetch_inst_i(fetch_inst_i),
		.retire_i(commit_valid_o), .retire_pc_i(commit_next_pc_o),
		.if_valid_o(if_valid), .if_pc_o(if_pc), .if_inst_o(if_inst)
	);

	rv_decode i_decode (
		.clock(clock), .reset(reset),
		.if_valid_i(if_valid), .if_pc_i(if_pc), .if_inst_i(if_inst),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.id_valid_o(id_valid), .id_pc_o(id_pc),
		.id_op_a_o(id_op_a), .id_op_b_o(id_op_b),
		.id_rs2_val_o(id_rs2_val), .id_imm_o(id_imm),
		.id_alu_op_o(id_alu_op), .id_next_pc_sel_o(id_next_pc_sel),
		.id_rd_o(id_rd), .id_rd_wen_o(id_rd_wen)
	);

	rv_regfile i_regfile (
		.clock(clock),
		.rs1_addr_i(rs1_addr), .rs1_data_o(rs1_data),
		.rs2_addr_i(rs2_addr), .rs2_data_o(rs2_data),
		.wr_en_i(commit_valid_o & commit_wen_o),
		.wr_addr_i(commit_rd_o), .wr_data_i(commit_data_o)
	);

	rv_execute i_execute (
		.clock(clock), .reset(reset),
		.id_valid_i(id_valid), .id_pc_i(id_pc),
		.id_op_a_i(id_op_a), .id_op_b_i(id_op_b),
		.id_rs2_val_i(id_rs2_val), .id_imm_i(id_imm),
		.id_alu_op_i(id_alu_op), .id_next_pc_sel_i(id_next_pc_sel),
		.id_rd_i(id_rd), .id_rd_wen_i(id_rd_wen),
		.commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
		.commit_wen_o(commit_wen_o), .commit_rd_o(commit_rd_o),
		.commit_data_o(commit_data_o), .commit_next_pc_o(commit_next_pc_o)
	);

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
	input logic clock,
	input logic reset,
	input logic id_valid_i,
	input rv_core_pkg::word_t id_pc_i,
	input rv_core_pkg::word_t id_op_a_i,
	input rv_core_pkg::word_t id_op_b_i,
	input rv_core_pkg::word_t id_rs2_val_i,
	input rv_core_pkg::word_t id_imm_i,
	input rv_core_pkg::alu_op_e id_alu_op_i,
	input rv_core_pkg::next_pc_sel_e id_next_pc_sel_i,
	input rv_core_pkg::reg_addr_t id_rd_i,
	input logic id_rd_wen_i,
	output logic commit_valid_o,
	output rv_core_pkg::word_t commit_pc_o,
	output logic commit_wen_o,
	output rv_core_pkg::reg_addr_t commit_rd_o,
	output rv_core_pkg::word_t commit_data_o,
	output rv_core_pkg::word_t commit_next_pc_o
);

	logic [4:0] shamt;
	rv_core_pkg::word_t alu_result;
	rv_core_pkg::word_t result;
	rv_core_pkg::word_t pc_plus4;
	rv_core_pkg::word_t pc_target;
	rv_core_pkg::word_t next_pc;

	assign shamt = id_op_b_i[4:0];
	assign pc_plus4 = id_pc_i + 32'd4;
	assign pc_target = id_pc_i + id_imm_i;

	always_comb begin
		alu_result = id_op_a_i + id_op_b_i;
		case (id_alu_op_i)
			rv_core_pkg::ALU_SUB: alu_result = id_op_a_i - id_op_b_i;
			rv_core_pkg::ALU_SLL: alu_result = id_op_a_i << shamt;
			rv_core_pkg::ALU_SLT: alu_result = {31'b0, $signed(id_op_a_i) < $signed(id_op_b_i)};
			rv_core_pkg::ALU_XOR: alu_result = id_op_a_i ^ id_op_b_i;
			rv_core_pkg::ALU_SRL: alu_result = id_op_a_i >> shamt;
			rv_core_pkg::ALU_SRA: alu_result = $signed(id_op_a_i) >>> shamt;
			rv_core_pkg::ALU_OR: alu_result = id_op_a_i | id_op_b_i;
			rv_core_pkg::ALU_AND: alu_result = id_op_a_i & id_op_b_i;
			rv_core_pkg::ALU_PASS_B: alu_result = id_op_b_i;
			default: ;
		endcase
	end

	// link value for jal
	assign result = (id_next_pc_sel_i == rv_core_pkg::NPC_JAL) ? pc_plus4 : alu_result;

	always_comb begin
		case (id_next_pc_sel_i)
			rv_core_pkg::NPC_JAL: next_pc = pc_target;
			rv_core_pkg::NPC_BEQ: next_pc = (id_op_a_i == id_rs2_val_i) ? pc_target : pc_plus4;
			rv_core_pkg::NPC_BNE: next_pc = (id_op_a_i != id_rs2_val_i) ? pc_target : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid_o <= 1'b0;
			commit_wen_o <= 1'b0;
		end else begin
			commit_valid_o <= id_valid_i;
			commit_wen_o <= id_valid_i & id_rd_wen_i;
		end
	end

	always_ff @(posedge clock) begin
		if (id_valid_i) begin
			commit_pc_o <= id_pc_i;
			commit_rd_o <= id_rd_i;
			commit_data_o <= result;
			commit_next_pc_o <= next_pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
	input logic clock,
	input logic reset,
	input logic if_valid_i,
	input rv_core_pkg::word_t if_pc_i,
	input rv_core_pkg::inst_t if_inst_i,
	output rv_core_pkg::reg_addr_t rs1_addr_o,
	output rv_core_pkg::reg_addr_t rs2_addr_o,
	input rv_core_pkg::word_t rs1_data_i,
	input rv_core_pkg::word_t rs2_data_i,
	output logic id_valid_o,
	output rv_core_pkg::word_t id_pc_o,
	output rv_core_pkg::word_t id_op_a_o,
	output rv_core_pkg::word_t id_op_b_o,
	output rv_core_pkg::word_t id_rs2_val_o,
	output rv_core_pkg::word_t id_imm_o,
	output rv_core_pkg::alu_op_e id_alu_op_o,
	output rv_core_pkg::next_pc_sel_e id_next_pc_sel_o,
	output rv_core_pkg::reg_addr_t id_rd_o,
	output logic id_rd_wen_o
);

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::word_t imm_i, imm_u, imm_j, imm_b;
	rv_core_pkg::word_t imm;
	rv_core_pkg::alu_op_e alu_op;
	rv_core_pkg::next_pc_sel_e next_sel;
	logic use_imm;
	logic rd_wen;

	assign opcode = if_inst_i[6:0];
	assign rd = if_inst_i[11:7];
	assign funct3 = if_inst_i[14:12];
	assign funct7 = if_inst_i[31:25];
	assign rs1_addr_o = if_inst_i[19:15];
	assign rs2_addr_o = if_inst_i[24:20];

	assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
	assign imm_u = {if_inst_i[31:12], 12'b0};
	assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
		if_inst_i[30:21], 1'b0};
	assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
		if_inst_i[11:8], 1'b0};

	always_comb begin
		alu_op = rv_core_pkg::ALU_ADD;
		next_sel = rv_core_pkg::NPC_SEQ;
		imm = imm_i;
		use_imm = 1'b1;
		rd_wen = 1'b0;
		case (opcode)
			OPC_OP_IMM, OPC_OP: begin
				use_imm = (opcode == OPC_OP_IMM);
				rd_wen = 1'b1;
				case (funct3)
					3'b000: begin
						// sub only exists in the register form
						if (opcode == OPC_OP && funct7[5]) begin
							alu_op = rv_core_pkg::ALU_SUB;
						end
					end
					3'b001: alu_op = rv_core_pkg::ALU_SLL;
					3'b010: alu_op = rv_core_pkg::ALU_SLT;
					3'b100: alu_op = rv_core_pkg::ALU_XOR;
					3'b101: alu_op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
					3'b110: alu_op = rv_core_pkg::ALU_OR;
					3'b111: alu_op = rv_core_pkg::ALU_AND;
					default: rd_wen = 1'b0;
				endcase
			end
			OPC_LUI: begin
				imm = imm_u;
				alu_op = rv_core_pkg::ALU_PASS_B;
				rd_wen = 1'b1;
			end
			OPC_JAL: begin
				imm = imm_j;
				next_sel = rv_core_pkg::NPC_JAL;
				rd_wen = 1'b1;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				use_imm = 1'b0;
				if (funct3 == 3'b000) begin
					next_sel = rv_core_pkg::NPC_BEQ;
				end else if (funct3 == 3'b001) begin
					next_sel = rv_core_pkg::NPC_BNE;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			id_valid_o <= 1'b0;
			id_rd_wen_o <= 1'b0;
		end else begin
			id_valid_o <= if_valid_i;
			if (if_valid_i) begin
				id_rd_wen_o <= rd_wen && (rd != '0);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (if_valid_i) begin
			id_pc_o <= if_pc_i;
			id_op_a_o <= rs1_data_i;
			id_op_b_o <= use_imm ? imm : rs2_data_i;
			id_rs2_val_o <= rs2_data_i;
			id_imm_o <= imm;
			id_alu_op_o <= alu_op;
			id_next_pc_sel_o <= next_sel;
			id_rd_o <= rd;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	output logic fetch_req_o,
	output rv_core_pkg::word_t fetch_addr_o,
	input logic fetch_valid_i,
	input rv_core_pkg::inst_t fetch_inst_i,
	input logic retire_i,
	input rv_core_pkg::word_t retire_pc_i,
	output logic if_valid_o,
	output rv_core_pkg::word_t if_pc_o,
	output rv_core_pkg::inst_t if_inst_o
);

	typedef enum logic [1:0] {
		ST_START,
		ST_WAIT_MEM,
		ST_WAIT_RETIRE
	} fetch_state_e;

	fetch_state_e state;
	rv_core_pkg::word_t pc;

	assign fetch_addr_o = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_START;
			pc <= RESET_PC;
			fetch_req_o <= 1'b0;
			if_valid_o <= 1'b0;
			if_inst_o <= rv_core_pkg::NOP_INST;
		end else begin
			fetch_req_o <= 1'b0;
			if_valid_o <= 1'b0;
			case (state)
				ST_START: begin
					fetch_req_o <= 1'b1;
					state <= ST_WAIT_MEM;
				end
				ST_WAIT_MEM: begin
					if (fetch_valid_i) begin
						if_valid_o <= 1'b1;
						if_inst_o <= fetch_inst_i;
						state <= ST_WAIT_RETIRE;
					end
				end
				ST_WAIT_RETIRE: begin
					// one instruction in flight so the next fetch waits for retire
					if (retire_i) begin
						pc <= retire_pc_i;
						fetch_req_o <= 1'b1;
						state <= ST_WAIT_MEM;
					end
				end
				default: state <= ST_START;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_WAIT_MEM && fetch_valid_i) begin
			if_pc_o <= pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
	input logic clock,
	input rv_core_pkg::reg_addr_t rs1_addr_i,
	output rv_core_pkg::word_t rs1_data_o,
	input rv_core_pkg::reg_addr_t rs2_addr_i,
	output rv_core_pkg::word_t rs2_data_o,
	input logic wr_en_i,
	input rv_core_pkg::reg_addr_t wr_addr_i,
	input rv_core_pkg::word_t wr_data_i
);

	rv_core_pkg::word_t regs [32];

	// x0 always reads zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	always_ff @(posedge clock) begin
		if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

	// architectural widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;

	// addi x0, x0, 0
	localparam inst_t NOP_INST = 32'h0000_0013;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// lui forwards the immediate
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		NPC_SEQ,
		NPC_JAL,
		NPC_BEQ,
		NPC_BNE
	} next_pc_sel_e;

endpackage

`default_nettype wire
